//--- files.f
hdl/ste_audio_pkg.sv
hdl/audio_regs.sv
hdl/audio_mixer.sv
hdl/sigma_delta_dac.sv
hdl/ste_audio_top.sv
verification/ste_audio_checker.sv
verification/ste_audio_tb.sv

//--- hdl/audio_mixer.sv
// psg and dma sound mixer

module audio_mixer (
	input  logic                             clk_32,
	input  logic                             xsint,
	// ym2149 channel levels, offset binary
	input  logic [ste_audio_pkg::PSG_W-1:0]  ym_a_i,
	input  logic [ste_audio_pkg::PSG_W-1:0]  ym_b_i,
	input  logic [ste_audio_pkg::PSG_W-1:0]  ym_c_i,
	// ste dma sound samples, offset binary
	input  logic [ste_audio_pkg::DMA_W-1:0]  dma_l_i,
	input  logic [ste_audio_pkg::DMA_W-1:0]  dma_r_i,
	// control
	input  logic                             psg_stereo_i,
	input  logic                             dma_snd_en_i,
	// registered mix
	output ste_audio_pkg::mix_t              mix_l_o,
	output ste_audio_pkg::mix_t              mix_r_o
);

	import ste_audio_pkg::*;

	logic [PSG_SUM_W-1:0] ym_a_ext;
	logic [PSG_SUM_W-1:0] ym_b_ext;
	logic [PSG_SUM_W-1:0] ym_c_ext;
	logic [PSG_SUM_W-1:0] psg_sum_l;
	logic [PSG_SUM_W-1:0] psg_sum_r;
	logic [PSG_SUM_W-1:0] psg_sgn_l;
	logic [PSG_SUM_W-1:0] psg_sgn_r;
	logic [DMA_W-1:0]     dma_sgn_l;
	logic [DMA_W-1:0]     dma_sgn_r;
	mix_t                 mix_l_d;
	mix_t                 mix_r_d;

	// widen both sources to MIX_W and add them
	// the low bits are filled with the top bits of the value so that
	// full scale maps close to full scale of the mix
	function automatic mix_t expand_mix(
		input logic [PSG_SUM_W-1:0] psg_v,
		input logic [DMA_W-1:0]     dma_v
	);
		logic [MIX_W-1:0] psg_term;
		logic [MIX_W-1:0] dma_term;
		psg_term = {psg_v[PSG_SUM_W-1], psg_v, psg_v[PSG_SUM_W-1 -: MIX_W-PSG_SUM_W-1]};
		dma_term = {dma_v[DMA_W-1], dma_v, dma_v[DMA_W-1 -: MIX_W-DMA_W-1]};
		return mix_t'(psg_term + dma_term);  // wraps modulo 2^15
	endfunction

	assign ym_a_ext = PSG_SUM_W'(ym_a_i);
	assign ym_b_ext = PSG_SUM_W'(ym_b_i);
	assign ym_c_ext = PSG_SUM_W'(ym_c_i);

	// stereo puts a left and c right, b on both sides
	assign psg_sum_l = psg_stereo_i ? (ym_a_ext + ym_b_ext) : (ym_a_ext + ym_b_ext + ym_c_ext);
	assign psg_sum_r = psg_stereo_i ? (ym_c_ext + ym_b_ext) : (ym_a_ext + ym_b_ext + ym_c_ext);

	// offset binary to two's complement
	assign psg_sgn_l = psg_sum_l - PSG_MID;
	assign psg_sgn_r = psg_sum_r - PSG_MID;

	// dma sound muted when disabled
	assign dma_sgn_l = dma_snd_en_i ? (dma_l_i - DMA_MID) : '0;
	assign dma_sgn_r = dma_snd_en_i ? (dma_r_i - DMA_MID) : '0;

	assign mix_l_d = expand_mix(psg_sgn_l, dma_sgn_l);
	assign mix_r_d = expand_mix(psg_sgn_r, dma_sgn_r);

	// one cycle of latency, new sample every clock
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_l_o <= '0;
			mix_r_o <= '0;
		end else begin
			mix_l_o <= mix_l_d;
			mix_r_o <= mix_r_d;
		end
	end

endmodule

//--- hdl/audio_regs.sv
// audio control registers

module audio_regs (
	input  logic                              clk_32,
	input  logic                              xsint,
	// apb slave
	input  logic                              psel_i,
	input  logic                              penable_i,
	input  logic                              pwrite_i,
	input  logic [ste_audio_pkg::APB_AW-1:0]  paddr_i,
	input  logic [ste_audio_pkg::APB_DW-1:0]  pwdata_i,
	output logic [ste_audio_pkg::APB_DW-1:0]  prdata_o,
	output logic                              pready_o,
	output logic                              pslverr_o,
	// mix readback
	input  ste_audio_pkg::mix_t               mix_l_i,
	input  ste_audio_pkg::mix_t               mix_r_i,
	// mixer control
	output logic                              psg_stereo_o,
	output logic                              dma_snd_en_o
);

	import ste_audio_pkg::*;

	logic [1:0] ctrl_q;        // [0] stereo, [1] dma enable
	logic       access_phase;
	logic       wr_ctrl;
	reg_addr_e  addr;

	assign access_phase = psel_i & penable_i;
	assign addr         = reg_addr_e'(paddr_i);

	// no wait states on this slave
	assign pready_o = 1'b1;

	// address decode, read mux and error response all in the access phase
	always_comb begin
		prdata_o  = '0;
		pslverr_o = 1'b0;
		wr_ctrl   = 1'b0;
		if (access_phase) begin
			case (addr)
				REG_CTRL: begin
					if (pwrite_i) begin
						wr_ctrl = 1'b1;
					end else begin
						prdata_o = {{(APB_DW-2){1'b0}}, ctrl_q};
					end
				end
				REG_MIX_L: begin
					if (pwrite_i) begin
						pslverr_o = 1'b1;  // read only
					end else begin
						prdata_o = {{(APB_DW-MIX_W){1'b0}}, mix_l_i};
					end
				end
				REG_MIX_R: begin
					if (pwrite_i) begin
						pslverr_o = 1'b1;  // read only
					end else begin
						prdata_o = {{(APB_DW-MIX_W){1'b0}}, mix_r_i};
					end
				end
				default: begin
					pslverr_o = 1'b1;  // unmapped
				end
			endcase
		end
	end

	// control bits, written at the edge closing the access phase
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ctrl_q <= CTRL_RESET;
		end else if (wr_ctrl) begin
			ctrl_q <= pwdata_i[1:0];
		end
	end

	assign psg_stereo_o = ctrl_q[0];
	assign dma_snd_en_o = ctrl_q[1];

endmodule

//--- hdl/sigma_delta_dac.sv
// first order sigma-delta dac

module sigma_delta_dac (
	input  logic                 clk_32,
	input  logic                 xsint,
	input  ste_audio_pkg::mix_t  mix_l_i,
	input  ste_audio_pkg::mix_t  mix_r_i,
	output logic                 audio_l_o,  // left bitstream
	output logic                 audio_r_o   // right bitstream
);

	import ste_audio_pkg::*;

	mix_t       mix_in [2];
	logic [1:0] bit_q;

	assign mix_in[0] = mix_l_i;
	assign mix_in[1] = mix_r_i;

	// one modulator per channel, 0 is left and 1 is right
	for (genvar ch = 0; ch < 2; ch++) begin : g_chan
		logic [MIX_W-1:0] level;
		logic [MIX_W-1:0] acc_q;
		logic [MIX_W:0]   acc_sum;

		// signed mix to unsigned level, midscale at 2^14
		assign level   = {~mix_in[ch][MIX_W-1], mix_in[ch][MIX_W-2:0]};
		assign acc_sum = {1'b0, acc_q} + {1'b0, level};

		always_ff @(posedge clk_32 or negedge xsint) begin
			if (!xsint) begin
				acc_q     <= '0;
				bit_q[ch] <= 1'b0;
			end else begin
				acc_q     <= acc_sum[MIX_W-1:0];
				bit_q[ch] <= acc_sum[MIX_W];  // carry is the output bit
			end
		end
	end

	assign audio_l_o = bit_q[0];
	assign audio_r_o = bit_q[1];

endmodule

//--- hdl/ste_audio_pkg.sv
// ste audio shared definitions

package ste_audio_pkg;

	// sample widths
	localparam int PSG_W     = 8;   // one ym2149 channel level
	localparam int PSG_SUM_W = 10;  // sum of up to three channels
	localparam int DMA_W     = 8;   // one ste dma sound sample
	localparam int MIX_W     = 15;  // mixed word, also the dac input

	// apb bus
	localparam int APB_AW = 4;
	localparam int APB_DW = 32;

	// offset binary midpoints, removed to get signed values
	localparam logic [PSG_SUM_W-1:0] PSG_MID = 10'd512;
	localparam logic [DMA_W-1:0]     DMA_MID = 8'd128;

	// control register after reset: mono psg, dma sound off
	localparam logic [1:0] CTRL_RESET = 2'b00;

	// register map
	typedef enum logic [APB_AW-1:0] {
		REG_CTRL  = 4'h0,  // bit 0 psg_stereo, bit 1 dma_snd_en
		REG_MIX_L = 4'h4,  // left mix, read only
		REG_MIX_R = 4'h8   // right mix, read only
	} reg_addr_e;

	// signed mix word per channel
	typedef logic signed [MIX_W-1:0] mix_t;

endpackage

//--- hdl/ste_audio_top.sv
// ste audio output path

module ste_audio_top (
	input  logic                              clk_32,
	input  logic                              xsint,
	// apb slave
	input  logic                              psel_i,
	input  logic                              penable_i,
	input  logic                              pwrite_i,
	input  logic [ste_audio_pkg::APB_AW-1:0]  paddr_i,
	input  logic [ste_audio_pkg::APB_DW-1:0]  pwdata_i,
	output logic [ste_audio_pkg::APB_DW-1:0]  prdata_o,
	output logic                              pready_o,
	output logic                              pslverr_o,
	// sample inputs
	input  logic [ste_audio_pkg::PSG_W-1:0]   ym_a_i,
	input  logic [ste_audio_pkg::PSG_W-1:0]   ym_b_i,
	input  logic [ste_audio_pkg::PSG_W-1:0]   ym_c_i,
	input  logic [ste_audio_pkg::DMA_W-1:0]   dma_l_i,
	input  logic [ste_audio_pkg::DMA_W-1:0]   dma_r_i,
	// dac bitstreams
	output logic                              audio_l_o,
	output logic                              audio_r_o
);

	import ste_audio_pkg::*;

	logic psg_stereo;
	logic dma_snd_en;
	mix_t mix_l;
	mix_t mix_r;

	audio_regs u_regs (
		.clk_32       (clk_32),
		.xsint        (xsint),
		.psel_i       (psel_i),
		.penable_i    (penable_i),
		.pwrite_i     (pwrite_i),
		.paddr_i      (paddr_i),
		.pwdata_i     (pwdata_i),
		.prdata_o     (prdata_o),
		.pready_o     (pready_o),
		.pslverr_o    (pslverr_o),
		.mix_l_i      (mix_l),     // readback of the live mix
		.mix_r_i      (mix_r),
		.psg_stereo_o (psg_stereo),
		.dma_snd_en_o (dma_snd_en)
	);

	audio_mixer u_mixer (
		.clk_32       (clk_32),
		.xsint        (xsint),
		.ym_a_i       (ym_a_i),
		.ym_b_i       (ym_b_i),
		.ym_c_i       (ym_c_i),
		.dma_l_i      (dma_l_i),
		.dma_r_i      (dma_r_i),
		.psg_stereo_i (psg_stereo),
		.dma_snd_en_i (dma_snd_en),
		.mix_l_o      (mix_l),
		.mix_r_o      (mix_r)
	);

	sigma_delta_dac u_dac (
		.clk_32    (clk_32),
		.xsint     (xsint),
		.mix_l_i   (mix_l),
		.mix_r_i   (mix_r),
		.audio_l_o (audio_l_o),
		.audio_r_o (audio_r_o)
	);

endmodule

//--- verification/ste_audio_checker.sv
// apb and reset assertions for the register block

module ste_audio_checker (
	input logic clk_32,
	input logic xsint,
	input logic psel_i,
	input logic penable_i,
	input logic pready_o,
	input logic pslverr_o,
	input logic psg_stereo_o,
	input logic dma_snd_en_o
);

	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0;  // read back by the testbench

	// slave never inserts wait states
	a_ready_in_access: assert property (@(posedge clk_32) disable iff (!xsint)
		(psel_i && penable_i) |-> pready_o)
	else begin
		$error("pready_o low during an apb access phase");
		fail_count++;
	end

	// error response only while the access phase is on the bus
	a_err_in_access: assert property (@(posedge clk_32) disable iff (!xsint)
		pslverr_o |-> (psel_i && penable_i))
	else begin
		$error("pslverr_o high outside an apb access phase");
		fail_count++;
	end

	// control bits held at their reset value during reset
	a_ctrl_in_reset: assert property (@(posedge clk_32)
		!xsint |-> (!psg_stereo_o && !dma_snd_en_o))
	else begin
		$error("control outputs not cleared while xsint is low");
		fail_count++;
	end

endmodule

//--- verification/ste_audio_tb.sv
// ste audio path testbench

module ste_audio_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import ste_audio_pkg::*;

	localparam int DAC_WINDOW     = 1 << MIX_W;  // cycles for one full accumulator turn
	localparam int TIMEOUT_CYCLES = 150000;      // three dac windows plus register tests

	logic              clk_32 = 1'b0;
	logic              xsint;
	logic              psel_i;
	logic              penable_i;
	logic              pwrite_i;
	logic [APB_AW-1:0] paddr_i;
	logic [APB_DW-1:0] pwdata_i;
	logic [APB_DW-1:0] prdata_o;
	logic              pready_o;
	logic              pslverr_o;
	logic [PSG_W-1:0]  ym_a_i;
	logic [PSG_W-1:0]  ym_b_i;
	logic [PSG_W-1:0]  ym_c_i;
	logic [DMA_W-1:0]  dma_l_i;
	logic [DMA_W-1:0]  dma_r_i;
	logic              audio_l_o;
	logic              audio_r_o;
	integer            seed;
	int                cycles = 0;

	ste_audio_top uut (.*);

	bind audio_regs ste_audio_checker u_checker (
		.clk_32       (clk_32),
		.xsint        (xsint),
		.psel_i       (psel_i),
		.penable_i    (penable_i),
		.pready_o     (pready_o),
		.pslverr_o    (pslverr_o),
		.psg_stereo_o (psg_stereo_o),
		.dma_snd_en_o (dma_snd_en_o)
	);

	always #20 clk_32 = ~clk_32;  // 25 MHz

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	always @(posedge clk_32) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			abort_run($sformatf("error: run did not finish within %0d cycles", TIMEOUT_CYCLES));
		end else if (uut.u_regs.u_checker.fail_count != 0) begin
			abort_run("error: an apb checker assertion failed");
		end
	end

	// expected mix word, straight from the mixing rule
	function automatic mix_t rule_mix(input logic [7:0] a, input logic [7:0] b,
			input logic [7:0] c, input logic [7:0] d, input logic stereo,
			input logic dma_en, input logic side_r);
		logic [9:0]  sum;
		logic [9:0]  psg_val;
		logic [7:0]  dma_val;
		logic [14:0] psg_term;
		logic [14:0] dma_term;
		if (!stereo) begin
			sum = {2'b00, a} + {2'b00, b} + {2'b00, c};
		end else if (side_r) begin
			sum = {2'b00, c} + {2'b00, b};
		end else begin
			sum = {2'b00, a} + {2'b00, b};
		end
		psg_val  = sum - 10'd512;
		dma_val  = dma_en ? (d - 8'd128) : 8'd0;
		psg_term = {psg_val[9], psg_val, psg_val[9:6]};
		dma_term = {dma_val[7], dma_val, dma_val[7:2]};
		return mix_t'(psg_term + dma_term);
	endfunction

	// unsigned dac level, signed mix plus half scale
	function automatic logic [31:0] dac_level(input mix_t m);
		return 32'(int'(m) + (1 << (MIX_W - 1)));
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic check_mix(input string name, input mix_t got, input mix_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_word(input string name, input logic [APB_DW-1:0] got,
			input logic [APB_DW-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic expect_err(input logic got, input logic want, input string what);
		if (got !== want) begin
			if (want) begin
				abort_run({"error: ", what, " did not raise pslverr_o"});
			end else begin
				abort_run({"error: ", what, " raised pslverr_o unexpectedly"});
			end
		end
	endtask

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
			output logic err);
		@(posedge clk_32);  // setup phase
		psel_i    <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i  <= 1'b1;
		paddr_i   <= addr;
		pwdata_i  <= data;
		@(posedge clk_32);
		penable_i <= 1'b1;
		@(negedge clk_32);  // mid access phase
		err = pslverr_o;
		@(posedge clk_32);  // write lands on this edge
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
		pwrite_i  <= 1'b0;
	endtask

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
			output logic err);
		@(posedge clk_32);
		psel_i    <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i  <= 1'b0;
		paddr_i   <= addr;
		@(posedge clk_32);
		penable_i <= 1'b1;
		@(negedge clk_32);
		data = prdata_o;
		err  = pslverr_o;
		@(posedge clk_32);
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
	endtask

	task automatic set_samples(input logic [7:0] a, input logic [7:0] b, input logic [7:0] c,
			input logic [7:0] dl, input logic [7:0] dr);
		@(posedge clk_32);
		ym_a_i  <= a;
		ym_b_i  <= b;
		ym_c_i  <= c;
		dma_l_i <= dl;
		dma_r_i <= dr;
	endtask

	// three cycles low, outputs checked just before release
	task automatic apply_reset();
		@(posedge clk_32);
		xsint <= 1'b0;
		repeat (2) @(posedge clk_32);
		@(negedge clk_32);
		check_word("audio_l_o", {31'b0, audio_l_o}, 32'h0);
		check_word("audio_r_o", {31'b0, audio_r_o}, 32'h0);
		check_word("pslverr_o", {31'b0, pslverr_o}, 32'h0);
		check_word("prdata_o", prdata_o, 32'h0);
		@(posedge clk_32);
		xsint <= 1'b1;
	endtask

	task automatic test_reset_values();
		logic [APB_DW-1:0] rd;
		logic              err;
		apb_read(REG_CTRL, rd, err);
		expect_err(err, 1'b0, "read of REG_CTRL");
		check_word("prdata_o ctrl", rd, 32'h0);
		apb_read(REG_MIX_L, rd, err);  // inputs sit at midpoint
		expect_err(err, 1'b0, "read of REG_MIX_L");
		check_word("prdata_o mix_l", rd, 32'h0);
		apb_read(REG_MIX_R, rd, err);
		expect_err(err, 1'b0, "read of REG_MIX_R");
		check_word("prdata_o mix_r", rd, 32'h0);
	endtask

	task automatic test_ctrl_errors();
		logic [APB_DW-1:0] rd;
		logic              err;
		apb_write(REG_CTRL, 32'h3, err);
		expect_err(err, 1'b0, "write of REG_CTRL");
		apb_read(REG_CTRL, rd, err);
		check_word("prdata_o ctrl", rd, 32'h3);
		apb_write(4'hc, 32'hffff_fffc, err);
		expect_err(err, 1'b1, "write to unmapped address 0xc");
		apb_read(4'h2, rd, err);
		expect_err(err, 1'b1, "read from unmapped address 0x2");
		apb_write(REG_MIX_L, 32'h0, err);
		expect_err(err, 1'b1, "write to read only REG_MIX_L");
		apb_read(REG_CTRL, rd, err);  // failed accesses leave ctrl alone
		check_word("prdata_o ctrl", rd, 32'h3);
	endtask

	task automatic mix_round(input logic stereo, input logic dma_en);
		logic [7:0]        a;
		logic [7:0]        b;
		logic [7:0]        c;
		logic [7:0]        dl;
		logic [7:0]        dr;
		logic [APB_DW-1:0] rd_l;
		logic [APB_DW-1:0] rd_r;
		logic              err;
		mix_t              exp_l;
		mix_t              exp_r;
		a  = rand_byte();
		b  = rand_byte();
		c  = rand_byte();
		dl = rand_byte();
		dr = rand_byte();
		exp_l = rule_mix(a, b, c, dl, stereo, dma_en, 1'b0);
		exp_r = rule_mix(a, b, c, dr, stereo, dma_en, 1'b1);
		set_samples(a, b, c, dl, dr);
		apb_read(REG_MIX_L, rd_l, err);
		expect_err(err, 1'b0, "read of REG_MIX_L");
		apb_read(REG_MIX_R, rd_r, err);
		expect_err(err, 1'b0, "read of REG_MIX_R");
		check_word("prdata_o mix_l upper bits", rd_l >> MIX_W, 32'h0);  // zero extended
		check_word("prdata_o mix_r upper bits", rd_r >> MIX_W, 32'h0);
		check_mix("mix_l_o", mix_t'(rd_l[MIX_W-1:0]), exp_l);
		check_mix("mix_r_o", mix_t'(rd_r[MIX_W-1:0]), exp_r);
		if (!stereo) begin
			check_mix("mix_r_o against mix_l_o", mix_t'(rd_r[MIX_W-1:0]), mix_t'(rd_l[MIX_W-1:0]));
		end
	endtask

	task automatic test_mono_mix();
		logic err;
		apb_write(REG_CTRL, 32'h0, err);
		expect_err(err, 1'b0, "write of REG_CTRL");
		repeat (8) mix_round(1'b0, 1'b0);
	endtask

	task automatic test_stereo_dma();
		logic err;
		apb_write(REG_CTRL, 32'h1, err);  // stereo alone first
		expect_err(err, 1'b0, "write of REG_CTRL");
		repeat (4) mix_round(1'b1, 1'b0);
		apb_write(REG_CTRL, 32'h3, err);
		expect_err(err, 1'b0, "write of REG_CTRL");
		repeat (8) mix_round(1'b1, 1'b1);
	endtask

	// count ones over one window, control back at reset value
	task automatic dac_window(input logic [7:0] a, input logic [7:0] b, input logic [7:0] c,
			input logic [7:0] dl, input logic [7:0] dr);
		logic [31:0] ones_l;
		logic [31:0] ones_r;
		logic [31:0] exp_l;
		logic [31:0] exp_r;
		ones_l = '0;
		ones_r = '0;
		exp_l  = dac_level(rule_mix(a, b, c, dl, 1'b0, 1'b0, 1'b0));
		exp_r  = dac_level(rule_mix(a, b, c, dr, 1'b0, 1'b0, 1'b1));
		set_samples(a, b, c, dl, dr);
		apply_reset();
		repeat (2) @(posedge clk_32);  // mix register then dac
		repeat (DAC_WINDOW) begin
			@(negedge clk_32);
			ones_l = ones_l + {31'b0, audio_l_o};
			ones_r = ones_r + {31'b0, audio_r_o};
		end
		check_word("audio_l_o ones count", ones_l, exp_l);
		check_word("audio_r_o ones count", ones_r, exp_r);
	endtask

	task automatic test_dac_density();
		dac_window(8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
		dac_window(8'hff, 8'hff, 8'hff, 8'hff, 8'hff);  // full scale
		dac_window(rand_byte(), rand_byte(), rand_byte(), rand_byte(), rand_byte());
	endtask

	initial begin
		seed      = 32'hd9f1;
		xsint     = 1'b1;
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
		paddr_i   = '0;
		pwdata_i  = '0;
		ym_a_i    = 8'hab;  // a+b+c = 512, psg midpoint
		ym_b_i    = 8'hab;
		ym_c_i    = 8'haa;
		dma_l_i   = 8'h80;
		dma_r_i   = 8'h80;
		apply_reset();
		test_reset_values();
		test_ctrl_errors();
		test_mono_mix();
		test_stereo_dma();
		test_dac_density();
		if (uut.u_regs.u_checker.fail_count != 0) begin
			abort_run($sformatf("error: %0d apb checker assertions failed",
				uut.u_regs.u_checker.fail_count));
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule
